/* sources.f */
verilog/rf_pkg.sv
verilog/reg_file.sv
verilog/operand_fetch.sv
verilog/exec_unit.sv
verilog/wb_regfile_slave.sv
verilog/rf_core_top.sv
testbench/rf_core_assertions.sv
testbench/rf_core_tb.sv

/* testbench/rf_core_assertions.sv */
// --------------------------------------------------
// Concurrent checks on the Wishbone slave and on
// the integer zero register, bound into rf_core_top
// Reaches the internal port A write bundle
// --------------------------------------------------
`timescale 1ns/1ps

module rf_core_assertions (
  input logic            clk,
  input logic            rst_n,
  input logic            cyc_i,
  input logic            stb_i,
  input logic            we_i,
  input rf_pkg::wb_adr_t adr_i,
  input rf_pkg::data_t   rdat_i,
  input logic            ack_i,
  input rf_pkg::rf_wr_t  wr_a_i
);

  // Ack is a single-cycle pulse
  a_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
    ack_i |=> !ack_i)
    else $error("wb_ack_o stayed high for more than one cycle");

  // Ack only answers a strobe that was not yet acked
  a_ack_after_stb: assert property (@(posedge clk) disable iff (!rst_n)
    ack_i |-> $past(cyc_i && stb_i && !ack_i))
    else $error("wb_ack_o raised without a pending cyc and stb");

  // No writeback while the core is held in reset
  a_no_wr_in_reset: assert property (@(posedge clk)
    !rst_n |-> !wr_a_i.we)
    else $error("port A write enable high during reset");

  // Integer register 0 reads as zero over the bus
  a_zero_reg: assert property (@(posedge clk) disable iff (!rst_n)
    (cyc_i && stb_i && !we_i && !ack_i && (adr_i == '0)) |=> (rdat_i == '0))
    else $error("bus read of register 0 returned a nonzero word");

endmodule

bind rf_core_top rf_core_assertions rf_core_assertions_i (
  .clk    (clk),
  .rst_n  (rst_n),
  .cyc_i  (wb_cyc_i),
  .stb_i  (wb_stb_i),
  .we_i   (wb_we_i),
  .adr_i  (wb_adr_i),
  .rdat_i (wb_dat_o),
  .ack_i  (wb_ack_o),
  .wr_a_i (wr_a)
);

/* testbench/rf_core_tb.sv */
// --------------------------------------------------
// Table-driven testbench for rf_core_top, FPU = 1
// Inputs change 2 ns after the rising edge
// One bus access per two cycles, so issues run
// back to back and exercise forwarding
// Expected data come from a sequential register model
// --------------------------------------------------
`timescale 1ns/1ps

module rf_core_tb;

  // Access kinds of the stimulus table
  typedef enum logic [1:0] {
    K_LOAD,
    K_ISSUE,
    K_READ
  } kind_e;

  typedef struct packed {
    kind_e           kind;
    rf_pkg::wb_adr_t adr;
    rf_pkg::data_t   dat;
  } entry_t;

  localparam int ACK_LATENCY = 1;
  localparam int ACK_WAIT    = 8;
  localparam int N_SWEEP     = 64;
  localparam int N_PRELOAD   = 16;
  localparam int N_PAIRS     = 40;

  logic            clk;
  logic            rst_n;
  logic            wb_cyc;
  logic            wb_stb;
  logic            wb_we;
  rf_pkg::wb_adr_t wb_adr;
  rf_pkg::data_t   wb_dat_w;
  rf_pkg::data_t   wb_dat_r;
  logic            wb_ack;

  entry_t        tab[$];
  // Register model, index 32 and up is the FP bank
  rf_pkg::data_t regs_model [64];
  int            errors;
  int            checks;
  int            cycle_cnt;
  int            cycle_limit;

  rf_core_top #(.FPU(1)) rf_core_top_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_dat_w),
    .wb_dat_o (wb_dat_r),
    .wb_ack_o (wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  // Integer register 0 and addresses past the window read zero
  function automatic rf_pkg::data_t expected_reg(input rf_pkg::wb_adr_t adr);
    rf_pkg::data_t val;
    val = '0;
    if ((adr <= rf_pkg::WB_REG_LAST) && (adr[5:0] != 6'd0)) begin
      val = regs_model[adr[5:0]];
    end
    return val;
  endfunction

  function automatic void store_reg(input rf_pkg::wb_adr_t adr, input rf_pkg::data_t dat);
    if (adr <= rf_pkg::WB_REG_LAST) begin
      regs_model[adr[5:0]] = dat;
    end
  endfunction

  // Arithmetic rule of each opcode, low 32 bits kept
  function automatic rf_pkg::data_t compute_result(input rf_pkg::data_t word);
    rf_pkg::instr_t ins;
    rf_pkg::data_t  a;
    rf_pkg::data_t  b;
    rf_pkg::data_t  c;
    rf_pkg::data_t  res;
    ins = rf_pkg::instr_t'(word[26:0]);
    a   = expected_reg({1'b0, ins.rs1});
    b   = expected_reg({1'b0, ins.rs2});
    c   = expected_reg({1'b0, ins.rs3});
    case (ins.op)
      rf_pkg::OP_ADD:  res = a + b;
      rf_pkg::OP_SUB:  res = a - b;
      rf_pkg::OP_AND:  res = a & b;
      rf_pkg::OP_XOR:  res = a ^ b;
      rf_pkg::OP_MUL:  res = a * b;
      rf_pkg::OP_MADD: res = a * b + c;
      default:         res = '0;
    endcase
    return res;
  endfunction

  function automatic rf_pkg::data_t make_instr(
    input rf_pkg::op_e       op,
    input rf_pkg::reg_addr_t rd,
    input rf_pkg::reg_addr_t rs1,
    input rf_pkg::reg_addr_t rs2,
    input rf_pkg::reg_addr_t rs3
  );
    rf_pkg::instr_t ins;
    ins = '{op: op, rd: rd, rs1: rs1, rs2: rs2, rs3: rs3};
    return {5'b0, ins};
  endfunction

  // --------------------------------------------------
  // Compare tasks
  // --------------------------------------------------
  task automatic check_data(input string name, input rf_pkg::data_t got,
                            input rf_pkg::data_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic check_ack(input int got);
    checks++;
    if (got != ACK_LATENCY) begin
      errors++;
      $display("Fail wb_ack_o latency: got 0x%0h, expected 0x%0h", got, ACK_LATENCY);
    end
  endtask

  // --------------------------------------------------
  // Bus tasks, entered 2 ns after a rising edge
  // --------------------------------------------------
  // Hold the strobe until ack, then one idle cycle
  task automatic complete_access(output rf_pkg::data_t rdat);
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      #2;
      cycles++;
    end while (!wb_ack && (cycles < ACK_WAIT));
    if (wb_ack) begin
      check_ack(cycles);
    end else begin
      errors++;
      $display("No ack from the slave within %0d cycles at address 0x%02h", ACK_WAIT, wb_adr);
    end
    rdat   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    @(posedge clk);
    #2;
  endtask

  task automatic write_bus(input rf_pkg::wb_adr_t adr, input rf_pkg::data_t dat);
    rf_pkg::data_t ignored;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = dat;
    complete_access(ignored);
  endtask

  task automatic read_bus(input rf_pkg::wb_adr_t adr, output rf_pkg::data_t dat);
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    complete_access(dat);
  endtask

  // --------------------------------------------------
  // Stimulus table
  // --------------------------------------------------
  function automatic void add_entry(input kind_e kind, input rf_pkg::wb_adr_t adr,
                                    input rf_pkg::data_t dat);
    tab.push_back('{kind: kind, adr: adr, dat: dat});
  endfunction

  function automatic void add_issue(input rf_pkg::op_e op, input rf_pkg::reg_addr_t rd,
                                    input rf_pkg::reg_addr_t rs1,
                                    input rf_pkg::reg_addr_t rs2,
                                    input rf_pkg::reg_addr_t rs3);
    add_entry(K_ISSUE, rf_pkg::WB_ISSUE_ADR, make_instr(op, rd, rs1, rs2, rs3));
  endfunction

  function automatic void build_table();
    // Both banks, register 0, address 64 and above
    add_entry(K_LOAD, 7'd5,  32'h1234_5678);
    add_entry(K_LOAD, 7'd37, 32'hCAFE_F00D);
    add_entry(K_LOAD, 7'd0,  32'hFFFF_FFFF);
    add_entry(K_LOAD, 7'd32, 32'hA5A5_0001);
    add_entry(K_LOAD, 7'd70, 32'h0BAD_0BAD);
    add_entry(K_READ, 7'd5,  '0);
    add_entry(K_READ, 7'd37, '0);
    add_entry(K_READ, 7'd0,  '0);
    add_entry(K_READ, 7'd32, '0);
    add_entry(K_READ, 7'd64, '0);
    add_entry(K_READ, 7'd70, '0);
    // Write to 70 must not alias onto register 6
    add_entry(K_READ, 7'd6,  '0);
    // Operands for the opcode tests
    add_entry(K_LOAD, 7'd1,  32'h0000_0064);
    add_entry(K_LOAD, 7'd2,  32'hFFFF_FFF9);
    add_entry(K_LOAD, 7'd3,  32'h0F0F_3C3C);
    add_entry(K_LOAD, 7'd33, 32'h0001_0003);
    add_issue(rf_pkg::OP_ADD, 6'd10, 6'd1, 6'd2, 6'd0);
    add_entry(K_READ, 7'd10, '0);
    add_issue(rf_pkg::OP_SUB, 6'd11, 6'd2, 6'd1, 6'd0);
    add_entry(K_READ, 7'd11, '0);
    add_issue(rf_pkg::OP_AND, 6'd12, 6'd3, 6'd2, 6'd0);
    add_entry(K_READ, 7'd12, '0);
    add_issue(rf_pkg::OP_XOR, 6'd44, 6'd3, 6'd33, 6'd0);
    add_entry(K_READ, 7'd44, '0);
    add_issue(rf_pkg::OP_MUL, 6'd13, 6'd2, 6'd33, 6'd0);
    add_entry(K_READ, 7'd13, '0);
    add_issue(rf_pkg::OP_MADD, 6'd45, 6'd1, 6'd2, 6'd3);
    add_entry(K_READ, 7'd45, '0);
    // Writeback to register 0 is lost
    add_issue(rf_pkg::OP_ADD, 6'd0, 6'd1, 6'd1, 6'd0);
    add_entry(K_READ, 7'd0, '0);
    // Dependent chain, each issue reads the one before
    add_issue(rf_pkg::OP_ADD, 6'd20, 6'd1, 6'd3, 6'd0);
    add_issue(rf_pkg::OP_MADD, 6'd21, 6'd20, 6'd2, 6'd20);
    add_issue(rf_pkg::OP_MUL, 6'd22, 6'd21, 6'd21, 6'd0);
    add_entry(K_READ, 7'd22, '0);
    add_entry(K_READ, 7'd21, '0);
    add_entry(K_READ, 7'd20, '0);
    // Load lands in the writeback cycle of the XOR
    add_issue(rf_pkg::OP_XOR, 6'd23, 6'd1, 6'd2, 6'd0);
    add_entry(K_LOAD, 7'd23, 32'hDEAD_BEEF);
    add_entry(K_READ, 7'd23, '0);
  endfunction

  task automatic apply_entry(input entry_t e);
    rf_pkg::instr_t ins;
    rf_pkg::data_t  got;
    ins = rf_pkg::instr_t'(e.dat[26:0]);
    case (e.kind)
      K_LOAD: begin
        write_bus(e.adr, e.dat);
        store_reg(e.adr, e.dat);
      end
      K_ISSUE: begin
        write_bus(e.adr, e.dat);
        store_reg({1'b0, ins.rd}, compute_result(e.dat));
      end
      default: begin
        read_bus(e.adr, got);
        check_data($sformatf("wb_dat_o @0x%02h", e.adr), got, expected_reg(e.adr));
      end
    endcase
  endtask

  // Random loads, then issue-then-read pairs
  task automatic run_random();
    rf_pkg::op_e       op;
    rf_pkg::reg_addr_t rd;
    rf_pkg::wb_adr_t   adr;
    rf_pkg::data_t     word;
    rf_pkg::data_t     got;
    for (int i = 0; i < N_PRELOAD; i++) begin
      adr  = rf_pkg::wb_adr_t'($urandom_range(63, 0));
      word = $urandom();
      write_bus(adr, word);
      store_reg(adr, word);
    end
    for (int i = 0; i < N_PAIRS; i++) begin
      op   = rf_pkg::op_e'($urandom_range(5, 0));
      rd   = rf_pkg::reg_addr_t'($urandom_range(63, 0));
      word = make_instr(op, rd, rf_pkg::reg_addr_t'($urandom_range(63, 0)),
                        rf_pkg::reg_addr_t'($urandom_range(63, 0)),
                        rf_pkg::reg_addr_t'($urandom_range(63, 0)));
      write_bus(rf_pkg::WB_ISSUE_ADR, word);
      store_reg({1'b0, rd}, compute_result(word));
      read_bus({1'b0, rd}, got);
      check_data($sformatf("wb_dat_o @0x%02h", rd), got, expected_reg({1'b0, rd}));
    end
  endtask

  // --------------------------------------------------
  // Timeout
  // --------------------------------------------------
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if ((cycle_limit > 0) && (cycle_cnt >= cycle_limit)) begin
      $display("Timeout after %0d cycles, the run did not complete", cycle_cnt);
      $display("TEST FAILED");
      $finish;
    end
  end

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin : main
    rf_pkg::data_t got;
    void'($urandom(38));
    rst_n     = 1'b0;
    wb_cyc    = 1'b0;
    wb_stb    = 1'b0;
    wb_we     = 1'b0;
    wb_adr    = '0;
    wb_dat_w  = '0;
    errors    = 0;
    checks    = 0;
    cycle_cnt = 0;
    foreach (regs_model[i]) begin
      regs_model[i] = '0;
    end
    build_table();
    // Each access takes two cycles
    cycle_limit = 4 * (N_SWEEP + tab.size() + N_PRELOAD + 2 * N_PAIRS) * 2 + 100;
    repeat (2) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // Every register is zero after reset
    for (int a = 0; a < N_SWEEP; a++) begin
      read_bus(rf_pkg::wb_adr_t'(a), got);
      check_data($sformatf("wb_dat_o @0x%02h", a), got, expected_reg(rf_pkg::wb_adr_t'(a)));
    end
    foreach (tab[i]) begin
      apply_entry(tab[i]);
    end
    run_random();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* verilog/exec_unit.sv */
// --------------------------------------------------
// Two-stage execute pipeline, never stalls
// Stage 1 holds operands and the 32-bit product
// Stage 2 holds the result as the port A write
// Results are the low 32 bits, no FP arithmetic
// --------------------------------------------------
`timescale 1ns/1ps

module exec_unit (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              op_valid_i,
  input  rf_pkg::op_e       op_i,
  input  rf_pkg::reg_addr_t rd_i,
  input  rf_pkg::data_t     opnd_a_i,
  input  rf_pkg::data_t     opnd_b_i,
  input  rf_pkg::data_t     opnd_c_i,
  output rf_pkg::rf_wr_t    wr_a_o
);

  // Stage 1
  logic              s1_valid_q;
  rf_pkg::op_e       s1_op_q;
  rf_pkg::reg_addr_t s1_rd_q;
  rf_pkg::data_t     s1_a_q;
  rf_pkg::data_t     s1_b_q;
  rf_pkg::data_t     s1_c_q;
  rf_pkg::data_t     s1_prod_q;
  // Stage 2
  logic              s2_valid_q;
  rf_pkg::reg_addr_t s2_rd_q;
  rf_pkg::data_t     s2_res_q;
  rf_pkg::data_t     result;

  // --------------------------------------------------
  // Valid bits
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= op_valid_i;
      s2_valid_q <= s1_valid_q;
    end
  end

  // --------------------------------------------------
  // Datapath
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    s1_op_q   <= op_i;
    s1_rd_q   <= rd_i;
    s1_a_q    <= opnd_a_i;
    s1_b_q    <= opnd_b_i;
    s1_c_q    <= opnd_c_i;
    // Multiply early, MADD adds rs3 in stage 2
    s1_prod_q <= opnd_a_i * opnd_b_i;
    s2_rd_q   <= s1_rd_q;
    s2_res_q  <= result;
  end

  always_comb begin : result_sel
    case (s1_op_q)
      rf_pkg::OP_ADD:  result = s1_a_q + s1_b_q;
      rf_pkg::OP_SUB:  result = s1_a_q - s1_b_q;
      rf_pkg::OP_AND:  result = s1_a_q & s1_b_q;
      rf_pkg::OP_XOR:  result = s1_a_q ^ s1_b_q;
      rf_pkg::OP_MUL:  result = s1_prod_q;
      rf_pkg::OP_MADD: result = s1_prod_q + s1_c_q;
      default:         result = '0;
    endcase
  end

  // Writeback on port A
  assign wr_a_o = '{we: s2_valid_q, addr: s2_rd_q, data: s2_res_q};

endmodule

/* verilog/operand_fetch.sv */
// --------------------------------------------------
// Operand fetch and port A forwarding
// Purely combinational, sits between slave and RF
// Port C reads rs3 during an issue, else the host
// read address; a host read and an issue never
// share a cycle since the bus acks every 2nd cycle
// Register 0 is never forwarded
// --------------------------------------------------
`timescale 1ns/1ps

module operand_fetch (
  input  rf_pkg::issue_t    issue_i,
  input  rf_pkg::reg_addr_t host_raddr_i,
  output rf_pkg::reg_addr_t raddr_a_o,
  output rf_pkg::reg_addr_t raddr_b_o,
  output rf_pkg::reg_addr_t raddr_c_o,
  input  rf_pkg::data_t     rdata_a_i,
  input  rf_pkg::data_t     rdata_b_i,
  input  rf_pkg::data_t     rdata_c_i,
  input  rf_pkg::rf_wr_t    wr_a_i,
  output logic              op_valid_o,
  output rf_pkg::op_e       op_o,
  output rf_pkg::reg_addr_t rd_o,
  output rf_pkg::data_t     opnd_a_o,
  output rf_pkg::data_t     opnd_b_o,
  output rf_pkg::data_t     opnd_c_o,
  output rf_pkg::data_t     host_rdata_o
);

  rf_pkg::instr_t instr;
  // Forwarded port C word, shared by rs3 and host reads
  rf_pkg::data_t  fwd_c;

  // Replace raw read data with the in-flight port A write
  function automatic rf_pkg::data_t fwd(
    input rf_pkg::reg_addr_t addr,
    input rf_pkg::data_t     raw,
    input rf_pkg::rf_wr_t    wr
  );
    rf_pkg::data_t res;
    res = raw;
    if (wr.we && (wr.addr == addr) && (addr != '0)) begin
      res = wr.data;
    end
    return res;
  endfunction

  // --------------------------------------------------
  // Decode
  // --------------------------------------------------
  assign instr      = issue_i.instr;
  assign op_valid_o = issue_i.valid;
  assign op_o       = instr.op;
  assign rd_o       = instr.rd;

  // Source addresses
  assign raddr_a_o = instr.rs1;
  assign raddr_b_o = instr.rs2;
  // Port C is shared with the host read path
  assign raddr_c_o = issue_i.valid ? instr.rs3 : host_raddr_i;

  // --------------------------------------------------
  // Forwarding
  // --------------------------------------------------
  // Same-cycle port B writes are not forwarded,
  // the port A value shows until the next read
  assign opnd_a_o = fwd(raddr_a_o, rdata_a_i, wr_a_i);
  assign opnd_b_o = fwd(raddr_b_o, rdata_b_i, wr_a_i);
  assign fwd_c    = fwd(raddr_c_o, rdata_c_i, wr_a_i);

  assign opnd_c_o     = fwd_c;
  assign host_rdata_o = fwd_c;

endmodule

/* verilog/reg_file.sv */
// --------------------------------------------------
// Flip-flop register file, 3 read and 2 write ports
// Integer register 0 always reads as zero
// FPU=1 adds 32 FP registers selected by bit 5
// FPU=0 ignores bit 5 on reads, drops writes to 32+
// Port B wins over port A on the same register
// Reads are raw, forwarding lives outside
// --------------------------------------------------
`timescale 1ns/1ps

module reg_file #(
  parameter int FPU = 1
) (
  input  logic              clk,
  input  logic              rst_n,
  input  rf_pkg::reg_addr_t raddr_a_i,
  input  rf_pkg::reg_addr_t raddr_b_i,
  input  rf_pkg::reg_addr_t raddr_c_i,
  output rf_pkg::data_t     rdata_a_o,
  output rf_pkg::data_t     rdata_b_o,
  output rf_pkg::data_t     rdata_c_o,
  input  rf_pkg::rf_wr_t    wr_a_i,
  input  rf_pkg::rf_wr_t    wr_b_i
);

  localparam int NUM_WORDS = 32;
  // Decoded write targets, FP bank only when present
  localparam int NUM_TOT   = (FPU != 0) ? 2 * NUM_WORDS : NUM_WORDS;

  // Integer bank without register 0
  rf_pkg::data_t     mem_int [1:NUM_WORDS-1];
  // One-hot write enables per port
  logic [NUM_TOT-1:0] we_a_dec;
  logic [NUM_TOT-1:0] we_b_dec;
  // Integer bank read data
  rf_pkg::data_t     int_a;
  rf_pkg::data_t     int_b;
  rf_pkg::data_t     int_c;

  // --------------------------------------------------
  // Write address decoders
  // --------------------------------------------------
  // Addresses above NUM_TOT-1 never match, so they are dropped
  always_comb begin : we_decoders
    for (int i = 0; i < NUM_TOT; i++) begin
      we_a_dec[i] = wr_a_i.we && (wr_a_i.addr == rf_pkg::reg_addr_t'(i));
      we_b_dec[i] = wr_b_i.we && (wr_b_i.addr == rf_pkg::reg_addr_t'(i));
    end
  end

  // --------------------------------------------------
  // Integer bank
  // --------------------------------------------------
  for (genvar i = 1; i < NUM_WORDS; i++) begin : g_int_regs
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        mem_int[i] <= '0;
      end else if (we_b_dec[i]) begin
        mem_int[i] <= wr_b_i.data;
      end else if (we_a_dec[i]) begin
        mem_int[i] <= wr_a_i.data;
      end
    end
  end

  // Register 0 is not stored, the low index is forced to zero
  always_comb begin : int_read
    int_a = (raddr_a_i[4:0] == 5'd0) ? '0 : mem_int[raddr_a_i[4:0]];
    int_b = (raddr_b_i[4:0] == 5'd0) ? '0 : mem_int[raddr_b_i[4:0]];
    int_c = (raddr_c_i[4:0] == 5'd0) ? '0 : mem_int[raddr_c_i[4:0]];
  end

  // --------------------------------------------------
  // Optional FP bank and read muxes
  // --------------------------------------------------
  if (FPU != 0) begin : g_fp_bank
    rf_pkg::data_t mem_fp [NUM_WORDS];

    // FP register 0 is an ordinary register
    for (genvar j = 0; j < NUM_WORDS; j++) begin : g_fp_regs
      always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
          mem_fp[j] <= '0;
        end else if (we_b_dec[j + NUM_WORDS]) begin
          mem_fp[j] <= wr_b_i.data;
        end else if (we_a_dec[j + NUM_WORDS]) begin
          mem_fp[j] <= wr_a_i.data;
        end
      end
    end

    assign rdata_a_o = raddr_a_i[5] ? mem_fp[raddr_a_i[4:0]] : int_a;
    assign rdata_b_o = raddr_b_i[5] ? mem_fp[raddr_b_i[4:0]] : int_b;
    assign rdata_c_o = raddr_c_i[5] ? mem_fp[raddr_c_i[4:0]] : int_c;
  end else begin : g_int_only
    // Bit 5 is a don't-care here
    assign rdata_a_o = int_a;
    assign rdata_b_o = int_b;
    assign rdata_c_o = int_c;
  end

endmodule

/* verilog/rf_core_top.sv */
// --------------------------------------------------
// Register file subsystem top level
// Wishbone classic slave in, no other outside ports
// FPU selects the optional FP bank
// Fixed latency, up to two instructions in flight
// --------------------------------------------------
`timescale 1ns/1ps

module rf_core_top #(
  parameter int FPU = 1
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            wb_cyc_i,
  input  logic            wb_stb_i,
  input  logic            wb_we_i,
  input  rf_pkg::wb_adr_t wb_adr_i,
  input  rf_pkg::data_t   wb_dat_i,
  output rf_pkg::data_t   wb_dat_o,
  output logic            wb_ack_o
);

  // --------------------------------------------------
  // Interconnect
  // --------------------------------------------------
  rf_pkg::issue_t    issue;
  rf_pkg::rf_wr_t    wr_a;
  rf_pkg::rf_wr_t    wr_b;
  rf_pkg::reg_addr_t host_raddr;
  rf_pkg::data_t     host_rdata;
  // Register file read ports
  rf_pkg::reg_addr_t raddr_a;
  rf_pkg::reg_addr_t raddr_b;
  rf_pkg::reg_addr_t raddr_c;
  rf_pkg::data_t     rdata_a;
  rf_pkg::data_t     rdata_b;
  rf_pkg::data_t     rdata_c;
  // Fetch to execute
  logic              op_valid;
  rf_pkg::op_e       op;
  rf_pkg::reg_addr_t rd;
  rf_pkg::data_t     opnd_a;
  rf_pkg::data_t     opnd_b;
  rf_pkg::data_t     opnd_c;

  wb_regfile_slave wb_regfile_slave_i (
    .clk, .rst_n, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i,
    .wb_dat_o, .wb_ack_o,
    .issue_o      (issue),
    .wr_b_o       (wr_b),
    .host_raddr_o (host_raddr),
    .host_rdata_i (host_rdata)
  );

  operand_fetch operand_fetch_i (
    .issue_i (issue), .host_raddr_i (host_raddr),
    .raddr_a_o (raddr_a), .raddr_b_o (raddr_b), .raddr_c_o (raddr_c),
    .rdata_a_i (rdata_a), .rdata_b_i (rdata_b), .rdata_c_i (rdata_c),
    .wr_a_i (wr_a), .op_valid_o (op_valid), .op_o (op), .rd_o (rd),
    .opnd_a_o (opnd_a), .opnd_b_o (opnd_b), .opnd_c_o (opnd_c),
    .host_rdata_o (host_rdata)
  );

  exec_unit exec_unit_i (
    .clk, .rst_n, .op_valid_i (op_valid), .op_i (op), .rd_i (rd),
    .opnd_a_i (opnd_a), .opnd_b_i (opnd_b), .opnd_c_i (opnd_c),
    .wr_a_o (wr_a)
  );

  reg_file #(.FPU(FPU)) reg_file_i (
    .clk, .rst_n,
    .raddr_a_i (raddr_a), .raddr_b_i (raddr_b), .raddr_c_i (raddr_c),
    .rdata_a_o (rdata_a), .rdata_b_o (rdata_b), .rdata_c_o (rdata_c),
    .wr_a_i (wr_a), .wr_b_i (wr_b)
  );

endmodule

/* verilog/rf_pkg.sv */
// --------------------------------------------------
// Shared types and the bus address map
// Widths are fixed here and are not parameters
// Instruction fields sit in the low 27 bits of a
// 32-bit bus word with the opcode on top
// --------------------------------------------------
package rf_pkg;

  // Register word and addresses
  typedef logic [31:0] data_t;
  // Bit 5 selects the FP bank
  typedef logic [5:0]  reg_addr_t;
  // Wishbone word address
  typedef logic [6:0]  wb_adr_t;

  // Opcodes of the execute pipeline
  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_AND  = 3'd2,
    OP_XOR  = 3'd3,
    // Low 32 bits of rs1 * rs2
    OP_MUL  = 3'd4,
    // rs1 * rs2 + rs3, low 32 bits
    OP_MADD = 3'd5
  } op_e;

  // Three-operand instruction, 27 bits
  typedef struct packed {
    op_e       op;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rs3;
  } instr_t;

  // One register file write port
  typedef struct packed {
    logic      we;
    reg_addr_t addr;
    data_t     data;
  } rf_wr_t;

  // Single-cycle issue pulse from the bus slave
  typedef struct packed {
    logic   valid;
    instr_t instr;
  } issue_t;

  // Address map, 0..63 is the register window
  localparam wb_adr_t WB_REG_LAST  = 7'd63;
  localparam wb_adr_t WB_ISSUE_ADR = 7'd64;

endpackage

/* verilog/wb_regfile_slave.sv */
// --------------------------------------------------
// Wishbone classic slave for the register window
// One ack per strobe, the cycle after cyc & stb;
// a held strobe gets an ack every second cycle
// Writes above 64 are acked and ignored
// Reads outside 0..63 return zero
// --------------------------------------------------
`timescale 1ns/1ps

module wb_regfile_slave (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              wb_cyc_i,
  input  logic              wb_stb_i,
  input  logic              wb_we_i,
  input  rf_pkg::wb_adr_t   wb_adr_i,
  input  rf_pkg::data_t     wb_dat_i,
  output rf_pkg::data_t     wb_dat_o,
  output logic              wb_ack_o,
  output rf_pkg::issue_t    issue_o,
  output rf_pkg::rf_wr_t    wr_b_o,
  output rf_pkg::reg_addr_t host_raddr_o,
  input  rf_pkg::data_t     host_rdata_i
);

  logic              ack_q;
  // New access, blocked in the ack cycle
  logic              req;
  logic              in_win;
  logic              is_issue;
  logic              wr_b_we_q;
  logic              issue_vld_q;
  logic              rd_win_q;
  rf_pkg::reg_addr_t raddr_q;
  rf_pkg::data_t     wdata_q;
  rf_pkg::instr_t    instr_q;

  // Address decode
  assign req      = wb_cyc_i && wb_stb_i && !ack_q;
  assign in_win   = (wb_adr_i <= rf_pkg::WB_REG_LAST);
  assign is_issue = (wb_adr_i == rf_pkg::WB_ISSUE_ADR);

  // --------------------------------------------------
  // Control, all active in the ack cycle
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ack_q       <= 1'b0;
      wr_b_we_q   <= 1'b0;
      issue_vld_q <= 1'b0;
      rd_win_q    <= 1'b0;
      raddr_q     <= '0;
    end else begin
      ack_q       <= req;
      wr_b_we_q   <= req && wb_we_i && in_win;
      issue_vld_q <= req && wb_we_i && is_issue;
      rd_win_q    <= req && !wb_we_i && in_win;
      // Register address of the access, held until the next one
      if (req) begin
        raddr_q <= wb_adr_i[5:0];
      end
    end
  end

  // Payload, qualified by the enables above
  always_ff @(posedge clk) begin
    if (req) begin
      wdata_q <= wb_dat_i;
      instr_q <= rf_pkg::instr_t'(wb_dat_i[$bits(rf_pkg::instr_t)-1:0]);
    end
  end

  // Port B target address shares the held bus address
  assign wr_b_o       = '{we: wr_b_we_q, addr: raddr_q, data: wdata_q};
  assign issue_o      = '{valid: issue_vld_q, instr: instr_q};
  assign host_raddr_o = raddr_q;
  assign wb_ack_o     = ack_q;
  assign wb_dat_o     = rd_win_q ? host_rdata_i : '0;

endmodule
